//--- logic/uart_alu_defines.svh
`ifndef UART_ALU_DEFINES_SVH
`define UART_ALU_DEFINES_SVH

////////////////////////////////
// serial frame format
////////////////////////////////

// data bits per frame, lsb first
`define UART_DATA_BITS 8

// ticks per bit, both directions
`define UART_OVERSAMPLE 16

////////////////////////////////
// time base
////////////////////////////////

// clocks per tick, 4 gives 64 clocks per bit
`define UART_TICK_DIV 4

`endif

//--- logic/uart_alu_pkg.sv
package uart_alu_pkg;

`include "uart_alu_defines.svh"

	// operand, result and serial byte
	typedef logic [`UART_DATA_BITS-1:0] data_t;

	typedef logic [$clog2(`UART_OVERSAMPLE)-1:0] tick_cnt_t; // ticks within a bit
	typedef logic [$clog2(`UART_DATA_BITS)-1:0]  bit_cnt_t;  // data bit index
	typedef logic [$clog2(`UART_TICK_DIV+1)-1:0] div_cnt_t; // clocks within a tick, +1 keeps div of 1 legal

	// shared by rx and tx
	typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_t;

	typedef enum logic [1:0] {WAIT_A, WAIT_B, WAIT_OP, SEND} frame_state_t;

	// mips funct codes
	typedef enum logic [7:0] {
		OP_ADD = 8'h20,
		OP_SUB = 8'h22,
		OP_AND = 8'h24,
		OP_OR  = 8'h25,
		OP_XOR = 8'h26,
		OP_NOR = 8'h27,
		OP_SRL = 8'h02,
		OP_SRA = 8'h03
	} alu_op_t;

endpackage

//--- logic/baud_tick_gen.sv
`timescale 1ns/10ps

`include "uart_alu_defines.svh"

module baud_tick_gen
(
	input  logic clk,
	input  logic arst_n,
	output logic tick // one clock wide, every UART_TICK_DIV clocks
);

	import uart_alu_pkg::*;

	localparam div_cnt_t div_last = div_cnt_t'(`UART_TICK_DIV - 1);

	div_cnt_t div_cnt;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end
		else
		begin
			tick <= (div_cnt == div_last); // registered, no glitches
			if (div_cnt == div_last)
				div_cnt <= '0; // wrap
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

//--- logic/uart_rx.sv
`timescale 1ns/10ps

`include "uart_alu_defines.svh"

module uart_rx
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic                tick,
	input  logic                rx_line,
	output uart_alu_pkg::data_t rx_data,      // lsb first shift reg
	output logic                rx_done_tick
);

	import uart_alu_pkg::*;

	localparam tick_cnt_t mid_tick  = tick_cnt_t'(`UART_OVERSAMPLE/2 - 1); // half a bit
	localparam tick_cnt_t last_tick = tick_cnt_t'(`UART_OVERSAMPLE - 1);   // full bit
	localparam bit_cnt_t  last_bit  = bit_cnt_t'(`UART_DATA_BITS - 1);

	uart_state_t state;
	tick_cnt_t   tick_cnt;
	bit_cnt_t    bit_cnt;
	logic        rx_meta;
	logic        rx_sync;

	// two flops, line is asynchronous to clk
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_meta <= 1'b1; // idle high
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
		end
	end

	////////////////////////////////
	// control fsm
	////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state        <= IDLE;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			rx_done_tick <= 1'b0;
		end
		else
		begin
			rx_done_tick <= 1'b0; // pulse default
			if (tick)
			begin
				case (state)
					IDLE:
					begin
						if (!rx_sync) // possible start edge
						begin
							state    <= START;
							tick_cnt <= '0;
						end
					end
					START:
					begin
						if (tick_cnt == mid_tick)
						begin
							tick_cnt <= '0;
							bit_cnt  <= '0;
							state    <= rx_sync ? IDLE : DATA; // high again, glitch
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					DATA:
					begin
						if (tick_cnt == last_tick) // mid of a data bit
						begin
							tick_cnt <= '0;
							if (bit_cnt == last_bit)
								state <= STOP;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					STOP:
					begin
						if (tick_cnt == last_tick) // mid stop bit, no framing check
						begin
							rx_done_tick <= 1'b1;
							state        <= IDLE;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	// payload, shifted in from the top
	always_ff @(posedge clk)
	begin
		if (tick && state == DATA && tick_cnt == last_tick)
			rx_data <= {rx_sync, rx_data[`UART_DATA_BITS-1:1]};
	end

endmodule

//--- logic/frame_ctrl.sv
`timescale 1ns/10ps

module frame_ctrl
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  uart_alu_pkg::data_t   rx_data,
	input  logic                  rx_done_tick,
	input  uart_alu_pkg::data_t   result,       // from alu, same cycle
	input  logic                  tx_done_tick,
	output uart_alu_pkg::data_t   operand_a,
	output uart_alu_pkg::data_t   operand_b,
	output uart_alu_pkg::alu_op_t op,
	output logic                  tx_start,     // one pulse per result
	output uart_alu_pkg::data_t   tx_data
);

	import uart_alu_pkg::*;

	frame_state_t state;
	logic         launched; // tx_start already sent for this result

	////////////////////////////////
	// byte sequencing
	////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= WAIT_A;
			launched <= 1'b0;
			tx_start <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0;
			case (state)
				WAIT_A:  if (rx_done_tick) state <= WAIT_B;
				WAIT_B:  if (rx_done_tick) state <= WAIT_OP;
				WAIT_OP: if (rx_done_tick) state <= SEND; // third byte
				SEND:
				begin
					// rx_done_tick ignored here
					if (!launched)
					begin
						tx_start <= 1'b1;
						launched <= 1'b1;
					end
					else if (tx_done_tick)
					begin
						launched <= 1'b0;
						state    <= WAIT_A;
					end
				end
				default: state <= WAIT_A;
			endcase
		end
	end

	// operand and result registers
	always_ff @(posedge clk)
	begin
		if (rx_done_tick)
		begin
			case (state)
				WAIT_A:  operand_a <= rx_data;
				WAIT_B:  operand_b <= rx_data;
				WAIT_OP: op        <= alu_op_t'(rx_data); // unknown codes kept as is
				default: ;
			endcase
		end
		if (state == SEND && !launched)
			tx_data <= result; // op settled by now
	end

endmodule

//--- logic/alu.sv
`timescale 1ns/10ps

module alu
(
	input  uart_alu_pkg::data_t   operand_a,
	input  uart_alu_pkg::data_t   operand_b,
	input  uart_alu_pkg::alu_op_t op,
	output uart_alu_pkg::data_t   result
);

	import uart_alu_pkg::*;

	logic [2:0] shamt; // only low 3 bits shift

	assign shamt = operand_b[2:0];

	always_comb
	begin
		case (op)
			OP_ADD: result = operand_a + operand_b; // wraps mod 256
			OP_SUB: result = operand_a - operand_b;
			OP_AND: result = operand_a & operand_b;
			OP_OR:  result = operand_a | operand_b;
			OP_XOR: result = operand_a ^ operand_b;
			OP_NOR: result = ~(operand_a | operand_b);
			OP_SRL: result = operand_a >> shamt;
			OP_SRA: result = data_t'($signed(operand_a) >>> shamt); // sign fill
			default: result = '0;
		endcase
	end

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/10ps

`include "uart_alu_defines.svh"

module uart_tx
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic                tick,
	input  logic                tx_start,
	input  uart_alu_pkg::data_t tx_data,
	output logic                tx_line,      // registered and idle high
	output logic                tx_done_tick
);

	import uart_alu_pkg::*;

	localparam tick_cnt_t last_tick = tick_cnt_t'(`UART_OVERSAMPLE - 1);
	localparam bit_cnt_t  last_bit  = bit_cnt_t'(`UART_DATA_BITS - 1);

	uart_state_t state;
	tick_cnt_t   tick_cnt;
	bit_cnt_t    bit_cnt;
	data_t       shift_reg; // lsb goes out first
	logic        bit_end;

	assign bit_end = tick && (tick_cnt == last_tick); // 16th tick of a bit

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state        <= IDLE;
			tick_cnt     <= '0;
			bit_cnt      <= '0;
			tx_line      <= 1'b1;
			tx_done_tick <= 1'b0;
		end
		else
		begin
			tx_done_tick <= 1'b0;
			case (state)
				IDLE:
				begin
					if (tx_start) // latched on any clock
					begin
						state    <= START;
						tick_cnt <= '0;
					end
				end
				START:
				begin
					if (bit_end)
					begin
						tx_line  <= shift_reg[0]; // first data bit
						tick_cnt <= '0;
						bit_cnt  <= '0;
						state    <= DATA;
					end
					else if (tick && tx_line)
						tx_line <= 1'b0; // start bit opens on the first tick
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				DATA:
				begin
					if (bit_end)
					begin
						tick_cnt <= '0;
						if (bit_cnt == last_bit)
						begin
							tx_line <= 1'b1; // stop bit
							state   <= STOP;
						end
						else
						begin
							tx_line <= shift_reg[1]; // next bit before the shift lands
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				STOP:
				begin
					if (bit_end)
					begin
						tx_done_tick <= 1'b1;
						tick_cnt     <= '0;
						state        <= IDLE;
					end
					else if (tick)
						tick_cnt <= tick_cnt + 1'b1;
				end
				default:
				begin
					tx_line <= 1'b1;
					state   <= IDLE;
				end
			endcase
		end
	end

	// data buffer
	always_ff @(posedge clk)
	begin
		if (state == IDLE && tx_start)
			shift_reg <= tx_data;
		else if (state == DATA && bit_end)
			shift_reg <= shift_reg >> 1;
	end

endmodule

//--- logic/uart_alu_top.sv
`timescale 1ns/10ps

module uart_alu_top
(
	input  logic clk,
	input  logic arst_n,
	input  logic rx_line, // from host, idle high
	output logic tx_line  // to host, idle high
);

	import uart_alu_pkg::*;

	logic    tick;          // shared oversampling time base
	data_t   rx_data;
	logic    rx_done_tick;
	data_t   operand_a;
	data_t   operand_b;
	alu_op_t op;
	data_t   result;
	logic    tx_start;
	data_t   tx_data;
	logic    tx_done_tick;

	////////////////////////////////
	// input side
	////////////////////////////////

	baud_tick_gen baud_tick_gen_i
	(
		.clk    (clk),
		.arst_n (arst_n),
		.tick   (tick)
	);

	uart_rx uart_rx_i
	(
		.clk          (clk),
		.arst_n       (arst_n),
		.tick         (tick),
		.rx_line      (rx_line),
		.rx_data      (rx_data),
		.rx_done_tick (rx_done_tick)
	);

	////////////////////////////////
	// processing
	////////////////////////////////

	frame_ctrl frame_ctrl_i
	(
		.clk          (clk),
		.arst_n       (arst_n),
		.rx_data      (rx_data),
		.rx_done_tick (rx_done_tick),
		.result       (result),
		.tx_done_tick (tx_done_tick),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.op           (op),
		.tx_start     (tx_start),
		.tx_data      (tx_data)
	);

	alu alu_i
	(
		.operand_a (operand_a),
		.operand_b (operand_b),
		.op        (op),
		.result    (result)
	);

	////////////////////////////////
	// output side
	////////////////////////////////

	uart_tx uart_tx_i
	(
		.clk          (clk),
		.arst_n       (arst_n),
		.tick         (tick),
		.tx_start     (tx_start),
		.tx_data      (tx_data),
		.tx_line      (tx_line),
		.tx_done_tick (tx_done_tick)
	);

endmodule

//--- test/uart_alu_tb.sv
`timescale 1ns/10ps

`include "uart_alu_defines.svh"

module uart_alu_tb;

	import uart_alu_pkg::*;

	localparam int bit_clks     = `UART_OVERSAMPLE * `UART_TICK_DIV; // clocks per serial bit
	localparam int recv_timeout = 12 * bit_clks; // op frame plus launch latency

	logic clk;
	logic arst_n;
	logic rx_line;
	logic tx_line;
	int   seed;

	uart_alu_top uart_alu_top_i
	(
		.clk     (clk),
		.arst_n  (arst_n),
		.rx_line (rx_line),
		.tx_line (tx_line)
	);

	always #50 clk = ~clk; // 100 ns period

	////////////////////////////////
	// checks and error exits
	////////////////////////////////

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic check_line(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// expected result worked bit by bit from the opcode table
	function automatic data_t model_alu(input data_t a, input data_t b, input logic [7:0] code);
		data_t r;
		int    sh;
		sh = b % 8; // low 3 bits only
		r  = a;
		case (code)
			8'h20: r = data_t'((int'(a) + int'(b)) % 256);
			8'h22: r = data_t'((int'(a) - int'(b) + 256) % 256); // borrow wraps
			8'h24: r = a & b;
			8'h25: r = a | b;
			8'h26: r = a ^ b;
			8'h27: r = ~(a | b);
			8'h02: repeat (sh) r = {1'b0, r[7:1]};
			8'h03: repeat (sh) r = {r[7], r[7:1]}; // sign fill
			default: r = 8'h00;
		endcase
		return r;
	endfunction

	////////////////////////////////
	// host serial model
	////////////////////////////////

	task automatic send_byte(input data_t b);
		int i;
		@(negedge clk);
		rx_line = 1'b0; // start bit
		repeat (bit_clks) @(negedge clk);
		for (i = 0; i < `UART_DATA_BITS; i++)
		begin
			rx_line = b[i]; // lsb first
			repeat (bit_clks) @(negedge clk);
		end
		rx_line = 1'b1; // stop bit
		repeat (bit_clks) @(negedge clk);
	endtask

	task automatic recv_byte(output data_t b);
		int waited;
		int i;
		waited = 0;
		@(negedge clk);
		while (tx_line !== 1'b0 && waited < recv_timeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (tx_line !== 1'b0)
			report_error("no start bit on tx_line before the timeout");
		repeat (bit_clks/2) @(negedge clk); // to mid start bit
		if (tx_line !== 1'b0)
			report_error("start bit on tx_line did not last to mid-bit");
		repeat (bit_clks/2 - 2) @(negedge clk); // just before the first data bit
		if (tx_line !== 1'b0)
			report_error("start bit on tx_line ended before a full bit time");
		repeat (bit_clks/2 + 2) @(negedge clk); // mid first data bit
		for (i = 0; i < `UART_DATA_BITS; i++)
		begin
			b[i] = tx_line;
			repeat (bit_clks) @(negedge clk);
		end
		if (tx_line !== 1'b1)
			report_error("stop bit on tx_line was low");
	endtask

	// one full transaction with the result returned while the op frame ends
	task automatic run_op(input string name, input data_t a, input data_t b,
		input logic [7:0] code);
		data_t got;
		send_byte(a);
		send_byte(b);
		fork
			send_byte(code);
			recv_byte(got);
		join
		check_data(name, model_alu(a, b, code), got);
	endtask

	////////////////////////////////
	// directed tests
	////////////////////////////////

	task automatic idle_after_reset();
		repeat (20 * bit_clks)
		begin
			@(negedge clk);
			check_line("reset_idle", 1'b1, tx_line);
		end
	endtask

	task automatic arith_ops();
		run_op("add_overflow", 8'hF0, 8'h20, 8'h20);
		run_op("add_plain", 8'h12, 8'h34, 8'h20);
		run_op("sub_borrow", 8'h05, 8'h09, 8'h22);
		run_op("sub_plain", 8'h80, 8'h01, 8'h22);
	endtask

	task automatic logic_ops();
		logic [7:0] codes [4];
		data_t      a;
		data_t      b;
		codes = '{8'h24, 8'h25, 8'h26, 8'h27};
		foreach (codes[k])
		begin
			for (int r = 0; r < 8; r++)
			begin
				a = data_t'($random(seed));
				b = data_t'($random(seed));
				run_op($sformatf("logic_%h_round%0d", codes[k], r), a, b, codes[k]);
			end
		end
	endtask

	task automatic shift_ops();
		data_t b;
		for (int sh = 0; sh < 8; sh++)
		begin
			b = {data_t'($random(seed)) & 8'hF8} | data_t'(sh); // upper bits must not matter
			run_op($sformatf("srl_pos_%0d", sh), 8'h5A, b, 8'h02);
			run_op($sformatf("srl_neg_%0d", sh), 8'hA5, b, 8'h02);
			run_op($sformatf("sra_pos_%0d", sh), 8'h5A, b, 8'h03);
			run_op($sformatf("sra_neg_%0d", sh), 8'hA5, b, 8'h03);
		end
	endtask

	task automatic unknown_opcode();
		run_op("unknown_op", 8'h3C, 8'h7E, 8'hFF);
		run_op("after_unknown", 8'h3C, 8'h7E, 8'h26); // framing still in step
	endtask

	task automatic glitch_rejection();
		@(negedge clk);
		rx_line = 1'b0; // short low of 3 ticks
		repeat (3 * `UART_TICK_DIV) @(negedge clk);
		rx_line = 1'b1;
		repeat (2 * bit_clks) @(negedge clk);
		run_op("after_glitch", 8'h21, 8'h13, 8'h20);
	endtask

	initial
	begin
		clk     = 1'b0;
		arst_n  = 1'b0;
		rx_line = 1'b1; // idle high
		seed    = 32'h8753_3505;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;

		idle_after_reset();
		arith_ops();
		logic_ops();
		shift_ops();
		unknown_opcode();
		glitch_rejection();

		$display("test passed");
		$finish;
	end

endmodule

//--- build.f
+incdir+logic/
logic/uart_alu_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/frame_ctrl.sv
logic/alu.sv
logic/uart_tx.sv
logic/uart_alu_top.sv
test/uart_alu_tb.sv
